/* compile.f */
+incdir+testbench
source/pifo_pkg.sv
source/pifo_min_select.sv
source/pifo_row_update.sv
source/pifo_node_ctrl.sv
source/pifo_node_port.sv
source/pifo_node.sv
testbench/tb_pifo_node.sv

/* source/pifo_min_select.sv */
`timescale 1ns/100ps

module pifo_min_select #(
   parameter type elem_t = pifo_pkg::value_t
) (
   input  elem_t                    i_elems [pifo_pkg::FANOUT],
   output pifo_pkg::slot_idx_t      o_min_idx
);

   elem_t               min_elem;   // Running minimum
   pifo_pkg::slot_idx_t min_idx;

   // Linear scan from slot 0
   // Strict compare keeps the earlier slot on a tie
   always_comb begin
      min_elem = i_elems[0];
      min_idx  = '0;
      for (int i = 1; i < pifo_pkg::FANOUT; i++) begin
         if (i_elems[i] < min_elem) begin
            min_elem = i_elems[i];
            min_idx  = pifo_pkg::slot_idx_t'(i);
         end
      end
   end

   assign o_min_idx = min_idx;

endmodule

/* source/pifo_node.sv */
`timescale 1ns/100ps

module pifo_node (
   input  logic                     i_clk,
   input  logic                     i_arst_n,

   // Parent
   input  logic                     i_push,
   input  logic                     i_pop,
   input  pifo_pkg::value_t         i_push_data,
   input  pifo_pkg::addr_t          i_my_addr,
   output pifo_pkg::value_t         o_pop_data,

   // Child
   output logic                     o_push,
   output pifo_pkg::value_t         o_push_data,
   output logic                     o_pop,
   input  pifo_pkg::value_t         i_pop_data,
   output pifo_pkg::addr_t          o_child_addr,

   // SRAM
   output logic                     o_read,
   input  pifo_pkg::row_t           i_read_data,
   output logic                     o_write,
   output pifo_pkg::row_t           o_write_data,
   output pifo_pkg::addr_t          o_read_addr,
   output pifo_pkg::addr_t          o_write_addr
);

   pifo_pkg::node_state_t state;
   pifo_pkg::value_t      push_value;   // Captured parent push value
   pifo_pkg::addr_t       node_addr;    // Captured row address

   pifo_pkg::row_t        push_row;
   pifo_pkg::row_t        pop_row;
   pifo_pkg::slot_idx_t   push_slot;
   pifo_pkg::slot_idx_t   pop_slot;
   logic                  push_down;
   logic                  pop_down;
   pifo_pkg::value_t      push_down_value;
   pifo_pkg::value_t      min_value;

   pifo_node_ctrl u_ctrl (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_push       (i_push),
      .i_pop        (i_pop),
      .i_push_data  (i_push_data),
      .i_my_addr    (i_my_addr),
      .o_state      (state),
      .o_push_value (push_value),
      .o_node_addr  (node_addr),
      .o_read       (o_read),
      .o_read_addr  (o_read_addr)
   );

   // Row arrives straight from SRAM, no local copy
   pifo_row_update u_row_update (
      .i_row              (i_read_data),
      .i_push_value       (push_value),
      .i_pop_data         (i_pop_data),
      .o_push_row         (push_row),
      .o_pop_row          (pop_row),
      .o_push_slot        (push_slot),
      .o_pop_slot         (pop_slot),
      .o_push_down        (push_down),
      .o_pop_down         (pop_down),
      .o_push_down_value  (push_down_value),
      .o_min_value        (min_value)
   );

   pifo_node_port u_port (
      .i_state            (state),
      .i_node_addr        (node_addr),
      .i_push_row         (push_row),
      .i_pop_row          (pop_row),
      .i_push_slot        (push_slot),
      .i_pop_slot         (pop_slot),
      .i_push_down        (push_down),
      .i_pop_down         (pop_down),
      .i_push_down_value  (push_down_value),
      .i_min_value        (min_value),
      .o_write            (o_write),
      .o_write_data       (o_write_data),
      .o_write_addr       (o_write_addr),
      .o_push             (o_push),
      .o_push_data        (o_push_data),
      .o_pop              (o_pop),
      .o_pop_data         (o_pop_data),
      .o_child_addr       (o_child_addr)
   );

endmodule

/* source/pifo_node_ctrl.sv */
`timescale 1ns/100ps

module pifo_node_ctrl (
   input  logic                     i_clk,
   input  logic                     i_arst_n,
   input  logic                     i_push,
   input  logic                     i_pop,
   input  pifo_pkg::value_t         i_push_data,
   input  pifo_pkg::addr_t          i_my_addr,
   output pifo_pkg::node_state_t    o_state,
   output pifo_pkg::value_t         o_push_value,
   output pifo_pkg::addr_t          o_node_addr,
   output logic                     o_read,
   output pifo_pkg::addr_t          o_read_addr
);

   pifo_pkg::node_state_t state;
   pifo_pkg::node_state_t state_nxt;
   logic                  can_accept;   // State allows a new command
   logic                  one_cmd;      // Exactly one of push / pop
   logic                  accept;
   pifo_pkg::value_t      push_value;
   pifo_pkg::addr_t       node_addr;

   // ------------------------------
   // Command acceptance
   // ------------------------------
   // POP cycle owns the child port, anything offered then is dropped
   assign can_accept = (state != pifo_pkg::POP);
   assign one_cmd    = i_push ^ i_pop;
   assign accept     = can_accept & one_cmd;

   always_comb begin
      state_nxt = pifo_pkg::IDLE;
      if (state == pifo_pkg::POP) begin
         state_nxt = pifo_pkg::WB;            // Always one cycle of write-back
      end else if (accept) begin
         if (i_push) begin
            state_nxt = pifo_pkg::PUSH;
         end else begin
            state_nxt = pifo_pkg::POP;
         end
      end
   end

   // ------------------------------
   // State register
   // ------------------------------
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state <= pifo_pkg::IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Address is needed by both paths, the value only by a push
   always_ff @(posedge i_clk) begin
      if (accept) begin
         node_addr <= i_my_addr;
      end
      if (accept && i_push) begin
         push_value <= i_push_data;
      end
   end

   // ------------------------------
   // Outputs
   // ------------------------------
   assign o_state      = state;
   assign o_push_value = push_value;
   assign o_node_addr  = node_addr;

   // SRAM read issued in the accepting cycle, data back next cycle
   assign o_read       = accept;
   assign o_read_addr  = i_my_addr;

endmodule

/* source/pifo_node_port.sv */
`timescale 1ns/100ps

module pifo_node_port (
   input  pifo_pkg::node_state_t    i_state,
   input  pifo_pkg::addr_t          i_node_addr,
   input  pifo_pkg::row_t           i_push_row,
   input  pifo_pkg::row_t           i_pop_row,
   input  pifo_pkg::slot_idx_t      i_push_slot,
   input  pifo_pkg::slot_idx_t      i_pop_slot,
   input  logic                     i_push_down,
   input  logic                     i_pop_down,
   input  pifo_pkg::value_t         i_push_down_value,
   input  pifo_pkg::value_t         i_min_value,
   output logic                     o_write,
   output pifo_pkg::row_t           o_write_data,
   output pifo_pkg::addr_t          o_write_addr,
   output logic                     o_push,
   output pifo_pkg::value_t         o_push_data,
   output logic                     o_pop,
   output pifo_pkg::value_t         o_pop_data,
   output pifo_pkg::addr_t          o_child_addr
);

   pifo_pkg::addr_t child_base;   // First child of this node

   assign child_base = pifo_pkg::addr_t'(i_node_addr * pifo_pkg::FANOUT);

   // ------------------------------
   // Output select by state
   // ------------------------------
   always_comb begin
      // Inactive values, also used in IDLE and WB
      o_write      = 1'b0;
      o_write_data = '0;
      o_push       = 1'b0;
      o_push_data  = '0;
      o_pop        = 1'b0;
      o_pop_data   = '1;
      o_child_addr = '1;

      case (i_state)
         pifo_pkg::PUSH: begin
            o_write      = 1'b1;
            o_write_data = i_push_row;
            o_push       = i_push_down;
            o_push_data  = i_push_down ? i_push_down_value : '0;
            o_child_addr = child_base + pifo_pkg::addr_t'(i_push_slot);
         end
         pifo_pkg::POP: begin
            o_write      = 1'b1;
            o_write_data = i_pop_row;
            o_pop        = i_pop_down;      // Low when the subtree is empty
            o_pop_data   = i_min_value;
            o_child_addr = child_base + pifo_pkg::addr_t'(i_pop_slot);
         end
         default: begin
         end
      endcase
   end

   assign o_write_addr = i_node_addr;   // Same row that was read

endmodule

/* source/pifo_pkg.sv */
package pifo_pkg;

   // ------------------------------
   // Widths
   // ------------------------------
   localparam int VALUE_W = 16;   // Priority value
   localparam int COUNT_W = 10;   // Subtree item count
   localparam int ADDR_W  = 20;   // SRAM row / node address
   localparam int FANOUT  = 4;    // Slots per row, children per node

   // ------------------------------
   // Types
   // ------------------------------
   typedef logic [VALUE_W-1:0]        value_t;
   typedef logic [COUNT_W-1:0]        count_t;
   typedef logic [ADDR_W-1:0]         addr_t;
   typedef logic [$clog2(FANOUT)-1:0] slot_idx_t;

   // Count sits above the value inside a slot
   typedef struct packed {
      count_t count;
      value_t value;
   } slot_t;

   // Slot 0 in the low bits of the row
   typedef slot_t [FANOUT-1:0] row_t;

   // Value held by a slot with nothing in it
   localparam value_t EMPTY_VALUE = '1;

   // ------------------------------
   // Node sequencer states
   // ------------------------------
   typedef enum logic [1:0] {
      IDLE = 2'b00,
      PUSH = 2'b01,   // Row back from SRAM, push update
      POP  = 2'b11,   // Row back from SRAM, pop update
      WB   = 2'b10    // Write settles, accepts like IDLE
   } node_state_t;

endpackage

/* source/pifo_row_update.sv */
`timescale 1ns/100ps

module pifo_row_update (
   input  pifo_pkg::row_t           i_row,
   input  pifo_pkg::value_t         i_push_value,
   input  pifo_pkg::value_t         i_pop_data,
   output pifo_pkg::row_t           o_push_row,
   output pifo_pkg::row_t           o_pop_row,
   output pifo_pkg::slot_idx_t      o_push_slot,
   output pifo_pkg::slot_idx_t      o_pop_slot,
   output logic                     o_push_down,
   output logic                     o_pop_down,
   output pifo_pkg::value_t         o_push_down_value,
   output pifo_pkg::value_t         o_min_value
);

   pifo_pkg::count_t    counts [pifo_pkg::FANOUT];
   pifo_pkg::value_t    values [pifo_pkg::FANOUT];
   pifo_pkg::slot_idx_t push_slot;
   pifo_pkg::slot_idx_t pop_slot;

   pifo_pkg::slot_t     push_old;   // Slot picked for the push
   pifo_pkg::slot_t     pop_old;    // Slot holding the row minimum
   logic                occupied;
   logic                new_wins;   // New value goes into the slot

   // Split row into count and value lanes
   always_comb begin
      for (int i = 0; i < pifo_pkg::FANOUT; i++) begin
         counts[i] = i_row[i].count;
         values[i] = i_row[i].value;
      end
   end

   // ------------------------------
   // Slot selection
   // ------------------------------
   // Push balances the tree, goes to the lightest subtree
   pifo_min_select #(
      .elem_t (pifo_pkg::count_t)
   ) u_min_count (
      .i_elems   (counts),
      .o_min_idx (push_slot)
   );

   // Pop takes the smallest value in the row
   pifo_min_select #(
      .elem_t (pifo_pkg::value_t)
   ) u_min_value (
      .i_elems   (values),
      .o_min_idx (pop_slot)
   );

   assign push_old = i_row[push_slot];
   assign pop_old  = i_row[pop_slot];

   // ------------------------------
   // Push update
   // ------------------------------
   assign occupied = (push_old.value != pifo_pkg::EMPTY_VALUE);
   assign new_wins = !occupied || (i_push_value < push_old.value);   // Equal keeps stored

   always_comb begin
      o_push_row = i_row;
      o_push_row[push_slot].count = push_old.count + pifo_pkg::count_t'(1);
      if (new_wins) begin
         o_push_row[push_slot].value = i_push_value;
      end else begin
         o_push_row[push_slot].value = push_old.value;
      end
   end

   // Loser of the compare moves down a level
   always_comb begin
      if (new_wins) begin
         o_push_down_value = push_old.value;
      end else begin
         o_push_down_value = i_push_value;
      end
   end

   assign o_push_down = occupied;   // Empty slot absorbs the item

   // ------------------------------
   // Pop update
   // ------------------------------
   always_comb begin
      o_pop_row  = i_row;
      o_pop_down = 1'b0;
      if (pop_old.count != '0) begin
         // Refill from the child subtree
         o_pop_row[pop_slot].value = i_pop_data;
         o_pop_row[pop_slot].count = pop_old.count - pifo_pkg::count_t'(1);
         o_pop_down                = 1'b1;
      end else begin
         o_pop_row[pop_slot].value = pifo_pkg::EMPTY_VALUE;   // Nothing below
      end
   end

   assign o_min_value = pop_old.value;
   assign o_push_slot = push_slot;
   assign o_pop_slot  = pop_slot;

endmodule

/* testbench/tb_pifo_checks.svh */
`ifndef TB_PIFO_CHECKS_SVH
`define TB_PIFO_CHECKS_SVH

// ------------------------------
// Compare tasks
// ------------------------------
task automatic check_value(input string name, input pifo_pkg::value_t got,
                           input pifo_pkg::value_t exp);
   if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
   end
endtask

task automatic check_row(input string name, input pifo_pkg::row_t got,
                         input pifo_pkg::row_t exp);
   if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
   end
endtask

task automatic check_addr(input string name, input pifo_pkg::addr_t got,
                          input pifo_pkg::addr_t exp);
   if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
   end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      stop_with_failure();
   end
endtask

// 32-bit xorshift step (13, 17, 5)
function automatic logic [31:0] xorshift32(input logic [31:0] x);
   logic [31:0] s;
   s = x;
   s = s ^ (s << 13);
   s = s ^ (s >> 17);
   s = s ^ (s << 5);
   return s;
endfunction

`endif

/* testbench/tb_pifo_node.sv */
`timescale 1ns/100ps

module tb_pifo_node;

   localparam int MAX_CYCLES = 2000;   // Tests need well under 100 cycles
   localparam int MEM_ROWS   = 64;

   logic                i_clk;
   logic                i_arst_n;
   logic                i_push;
   logic                i_pop;
   pifo_pkg::value_t    i_push_data;
   pifo_pkg::addr_t     i_my_addr;
   pifo_pkg::value_t    o_pop_data;
   logic                o_push;
   pifo_pkg::value_t    o_push_data;
   logic                o_pop;
   pifo_pkg::value_t    i_pop_data;
   pifo_pkg::addr_t     o_child_addr;
   logic                o_read;
   pifo_pkg::row_t      i_read_data;
   logic                o_write;
   pifo_pkg::row_t      o_write_data;
   pifo_pkg::addr_t     o_read_addr;
   pifo_pkg::addr_t     o_write_addr;

   pifo_pkg::row_t      sram [MEM_ROWS];
   logic [31:0]         rng_state = 32'h3fbf4231;
   int                  cycle_count = 0;

   pifo_node DUT (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_push       (i_push),
      .i_pop        (i_pop),
      .i_push_data  (i_push_data),
      .i_my_addr    (i_my_addr),
      .o_pop_data   (o_pop_data),
      .o_push       (o_push),
      .o_push_data  (o_push_data),
      .o_pop        (o_pop),
      .i_pop_data   (i_pop_data),
      .o_child_addr (o_child_addr),
      .o_read       (o_read),
      .i_read_data  (i_read_data),
      .o_write      (o_write),
      .o_write_data (o_write_data),
      .o_read_addr  (o_read_addr),
      .o_write_addr (o_write_addr)
   );

   initial i_clk = 1'b0;
   always #50 i_clk = ~i_clk;

   // SRAM model with read data one cycle after the strobe
   always @(posedge i_clk) begin
      if (o_read) begin
         i_read_data <= sram[o_read_addr[5:0]];
      end
      if (o_write) begin
         sram[o_write_addr[5:0]] <= o_write_data;
      end
   end

   always @(posedge i_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
         stop_with_failure();
      end
   end

   task automatic stop_with_failure();
      $display("tests failed");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   `include "tb_pifo_checks.svh"

   // Never returns the empty marker
   function automatic pifo_pkg::value_t random_value();
      rng_state = xorshift32(rng_state);
      if (rng_state[15:0] == pifo_pkg::EMPTY_VALUE) begin
         return pifo_pkg::EMPTY_VALUE - 1;
      end
      return rng_state[15:0];
   endfunction

   function automatic pifo_pkg::slot_t make_slot(input pifo_pkg::count_t c,
                                                 input pifo_pkg::value_t v);
      return {c, v};
   endfunction

   task automatic load_row(input pifo_pkg::addr_t addr, input pifo_pkg::row_t row);
      @(negedge i_clk);
      sram[addr[5:0]] = row;
   endtask

   // ------------------------------
   // Command issue
   // ------------------------------
   // Returns in the PUSH or POP cycle with the inputs idle
   task automatic issue(input logic push, input logic pop,
                        input pifo_pkg::value_t value, input pifo_pkg::addr_t addr);
      @(negedge i_clk);
      i_push      = push;
      i_pop       = pop;
      i_push_data = value;
      i_my_addr   = addr;
      #1;
      check_bit("o_read", o_read, 1'b1);
      check_addr("o_read_addr", o_read_addr, addr);
      @(negedge i_clk);
      i_push = 1'b0;
      i_pop  = 1'b0;
      #1;
      check_bit("o_write", o_write, 1'b1);
      check_addr("o_write_addr", o_write_addr, addr);
   endtask

   task automatic test_reset_values();
      @(negedge i_clk);
      #1;
      check_bit("o_read", o_read, 1'b0);
      check_bit("o_write", o_write, 1'b0);
      check_bit("o_push", o_push, 1'b0);
      check_bit("o_pop", o_pop, 1'b0);
      check_value("o_pop_data", o_pop_data, '1);
      check_addr("o_child_addr", o_child_addr, '1);
   endtask

   task automatic test_fill_empty_row();
      pifo_pkg::addr_t  addr;
      pifo_pkg::row_t   expected;
      pifo_pkg::value_t value;
      addr = 20'h00007;
      for (int i = 0; i < 4; i++) begin
         expected[i] = make_slot('0, pifo_pkg::EMPTY_VALUE);
      end
      for (int i = 0; i < 4; i++) begin
         value = random_value();
         issue(1'b1, 1'b0, value, addr);
         expected[i] = make_slot(1, value);   // Slot i is the first with count 0
         check_row("o_write_data", o_write_data, expected);
         check_bit("o_push", o_push, 1'b0);
      end
   endtask

   task automatic test_push_full_row();
      pifo_pkg::addr_t addr;
      pifo_pkg::row_t  start;
      pifo_pkg::row_t  expected;
      addr = 20'h00009;
      for (int i = 0; i < 4; i++) begin
         start[i] = make_slot(2, pifo_pkg::value_t'(100 * (i + 1)));
      end
      // New value smaller than slot 0 so the stored value moves down
      load_row(addr, start);
      issue(1'b1, 1'b0, 16'd40, addr);
      expected    = start;
      expected[0] = make_slot(3, 16'd40);
      check_bit("o_push", o_push, 1'b1);
      check_value("o_push_data", o_push_data, 16'd100);
      check_addr("o_child_addr", o_child_addr, pifo_pkg::addr_t'(addr * 4));
      check_row("o_write_data", o_write_data, expected);
      // New value larger so it goes down itself
      load_row(addr, start);
      issue(1'b1, 1'b0, 16'd150, addr);
      expected[0] = make_slot(3, 16'd100);
      check_bit("o_push", o_push, 1'b1);
      check_value("o_push_data", o_push_data, 16'd150);
      check_addr("o_child_addr", o_child_addr, pifo_pkg::addr_t'(addr * 4));
      check_row("o_write_data", o_write_data, expected);
   endtask

   task automatic test_pop_refill();
      pifo_pkg::addr_t  addr;
      pifo_pkg::row_t   start;
      pifo_pkg::row_t   expected;
      pifo_pkg::value_t child;
      addr     = 20'h0000b;
      start[0] = make_slot(1, 16'd500);   // Fewest items
      start[1] = make_slot(3, 16'd120);   // Row minimum
      start[2] = make_slot(2, 16'd300);
      start[3] = make_slot(4, 16'd260);
      child    = random_value();
      load_row(addr, start);
      i_pop_data = child;
      issue(1'b0, 1'b1, '0, addr);
      expected    = start;
      expected[1] = make_slot(2, child);
      check_value("o_pop_data", o_pop_data, 16'd120);
      check_bit("o_pop", o_pop, 1'b1);
      check_bit("o_push", o_push, 1'b0);
      check_addr("o_child_addr", o_child_addr, pifo_pkg::addr_t'(addr * 4 + 1));
      check_row("o_write_data", o_write_data, expected);
      @(negedge i_clk);
      #1;
      check_bit("o_write", o_write, 1'b0);   // WB cycle
   endtask

   task automatic test_pop_empty_subtree();
      pifo_pkg::addr_t addr;
      pifo_pkg::row_t  start;
      pifo_pkg::row_t  expected;
      addr     = 20'h0000c;
      start[0] = make_slot(0, 16'd400);   // Lowest index among the fewest items
      start[1] = make_slot(0, 16'd90);
      start[2] = make_slot(1, 16'd300);
      start[3] = make_slot(5, 16'd250);
      load_row(addr, start);
      i_pop_data = random_value();
      issue(1'b0, 1'b1, '0, addr);
      expected    = start;
      expected[1] = make_slot(0, pifo_pkg::EMPTY_VALUE);
      check_value("o_pop_data", o_pop_data, 16'd90);
      check_bit("o_pop", o_pop, 1'b0);
      check_row("o_write_data", o_write_data, expected);
   endtask

   task automatic test_ignored_commands();
      pifo_pkg::addr_t addr;
      addr = 20'h0000d;
      @(negedge i_clk);
      i_push    = 1'b1;
      i_pop     = 1'b1;
      i_my_addr = addr;
      #1;
      check_bit("o_read", o_read, 1'b0);
      @(negedge i_clk);
      i_push = 1'b0;
      i_pop  = 1'b0;
      #1;
      check_bit("o_write", o_write, 1'b0);
      // Push offered during the POP cycle
      @(negedge i_clk);
      i_pop = 1'b1;
      @(negedge i_clk);
      i_pop       = 1'b0;
      i_push      = 1'b1;
      i_push_data = random_value();
      #1;
      check_bit("o_read", o_read, 1'b0);
      @(negedge i_clk);
      i_push = 1'b0;
      #1;
      check_bit("o_write", o_write, 1'b0);
      check_bit("o_read", o_read, 1'b0);
   endtask

   initial begin
      i_arst_n    = 1'b0;
      i_push      = 1'b0;
      i_pop       = 1'b0;
      i_push_data = '0;
      i_my_addr   = '0;
      i_pop_data  = '0;
      i_read_data = '0;
      for (int r = 0; r < MEM_ROWS; r++) begin
         for (int s = 0; s < 4; s++) begin
            sram[r][s] = make_slot('0, pifo_pkg::EMPTY_VALUE);
         end
      end
      repeat (5) @(negedge i_clk);
      i_arst_n = 1'b1;
      test_reset_values();
      test_fill_empty_row();
      test_push_full_row();
      test_pop_refill();
      test_pop_empty_subtree();
      test_ignored_commands();
      $display("all tests passed");
      $finish;
   end

endmodule
